// ==== fetch_pkg.sv ====
package fetch_pkg;

    // Byte address or program counter.
    typedef logic [31:0] addr_t;

    // Aligned word as returned by instruction memory.
    typedef logic [31:0] word_t;

    // One queue entry.
    typedef logic [15:0] half_t;

    // Instruction to decode. Upper half is zero for compressed ones.
    typedef logic [31:0] instr_t;

    localparam int FETCH_BUF_HALVES = 8;

    // Fill count of the halfword queue, 0 up to FETCH_BUF_HALVES.
    localparam int FETCH_BUF_CNT_W = $clog2(FETCH_BUF_HALVES + 1);

    typedef logic [FETCH_BUF_CNT_W-1:0] buf_cnt_t;

    localparam addr_t RESET_PC = 32'h0000_0100;

    // Four-phase handshake toward instruction memory.
    typedef enum logic [1:0]
    {
        CTRL_IDLE,    // No request outstanding.
        CTRL_REQ,     // Request high, waiting for ack.
        CTRL_RELEASE  // Request dropped, waiting for ack to fall.
    } ctrl_state_t;

endpackage

// ==== fetch_push_if.sv ====
`timescale 1ns/1ps

interface fetch_push_if;

    logic              push;        // One-cycle strobe.
    logic              upper_only;  // Queue only bits 31:16 of data.
    fetch_pkg::word_t  data;
    logic              flush;
    fetch_pkg::addr_t  flush_pc;    // First PC after the flush.
    logic              free_dword;  // Two or more entries free after this cycle's pop.

    modport ctrl
    (
        output push,
        output upper_only,
        output data,
        output flush,
        output flush_pc,
        input  free_dword
    );

    modport queue
    (
        input  push,
        input  upper_only,
        input  data,
        input  flush,
        input  flush_pc,
        output free_dword
    );

endinterface

// ==== fetch_ctrl.sv ====
`timescale 1ns/1ps

module fetch_ctrl
(
    input  logic                i_clk,
    input  logic                i_reset_n,
    input  logic                i_redirect,
    input  fetch_pkg::addr_t    i_redirect_pc,
    input  logic                i_mem_ack,
    input  fetch_pkg::word_t    i_mem_data,
    input  fetch_pkg::addr_t    i_fetch_addr,
    input  logic                i_upper_only,
    output logic                o_mem_req,
    output fetch_pkg::addr_t    o_mem_addr,
    output logic                o_load,
    output fetch_pkg::addr_t    o_load_pc,
    output logic                o_advance,
    fetch_push_if.ctrl          push_if
);

    fetch_pkg::ctrl_state_t state;
    fetch_pkg::ctrl_state_t state_next;
    fetch_pkg::addr_t       mem_addr_q;
    fetch_pkg::word_t       data_q;
    logic                   stale;
    logic                   push_q;
    logic                   start_req;
    logic                   ack_seen;

    // A redirect in the idle cycle delays the request by one cycle, so the
    // latched address is always the loaded one.
    assign start_req = (state == fetch_pkg::CTRL_IDLE) && push_if.free_dword && !i_redirect;
    assign ack_seen  = (state == fetch_pkg::CTRL_REQ) && i_mem_ack;

    always_comb
    begin
        state_next = state;
        case (state)
            fetch_pkg::CTRL_IDLE:
                if (start_req)
                    state_next = fetch_pkg::CTRL_REQ;
            fetch_pkg::CTRL_REQ:
                if (i_mem_ack)
                    state_next = fetch_pkg::CTRL_RELEASE;
            fetch_pkg::CTRL_RELEASE:
                if (!i_mem_ack)
                    state_next = fetch_pkg::CTRL_IDLE;
            default:
                state_next = fetch_pkg::CTRL_IDLE;
        endcase
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            state  <= fetch_pkg::CTRL_IDLE;
            stale  <= 1'b0;
            push_q <= 1'b0;
        end
        else
        begin
            state  <= state_next;
            push_q <= ack_seen && !stale && !i_redirect;  // Old data is dropped.
            if (state == fetch_pkg::CTRL_REQ)
                stale <= i_mem_ack ? 1'b0 : (stale | i_redirect);
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (start_req)
            mem_addr_q <= i_fetch_addr;  // Held for the whole handshake.
        if (ack_seen)
            data_q <= i_mem_data;
    end

    assign o_mem_req  = (state == fetch_pkg::CTRL_REQ);
    assign o_mem_addr = mem_addr_q;

    // Redirect reaches the address generator and the queue on the same edge.
    assign o_load    = i_redirect;
    assign o_load_pc = i_redirect_pc;
    assign o_advance = push_q;

    assign push_if.push       = push_q;
    assign push_if.upper_only = i_upper_only;
    assign push_if.data       = data_q;
    assign push_if.flush      = i_redirect;
    assign push_if.flush_pc   = i_redirect_pc;

endmodule

// ==== fetch_addr_gen.sv ====
`timescale 1ns/1ps

module fetch_addr_gen
(
    input  logic                i_clk,
    input  logic                i_reset_n,
    input  logic                i_load,
    input  fetch_pkg::addr_t    i_load_pc,
    input  logic                i_advance,
    output fetch_pkg::addr_t    o_fetch_addr,
    output logic                o_upper_only
);

    fetch_pkg::addr_t fetch_addr;
    logic             upper_only;

    // A load wins over an advance in the same cycle. The word in flight
    // then belongs to the old stream.
    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            fetch_addr <= {fetch_pkg::RESET_PC[31:2], 2'b00};
            upper_only <= fetch_pkg::RESET_PC[1];
        end
        else if (i_load)
        begin
            fetch_addr <= {i_load_pc[31:2], 2'b00};
            upper_only <= i_load_pc[1];  // Start in the upper half.
        end
        else if (i_advance)
        begin
            fetch_addr <= fetch_addr + 32'd4;
            upper_only <= 1'b0;
        end
    end

    assign o_fetch_addr = fetch_addr;
    assign o_upper_only = upper_only;

endmodule

// ==== fetch_buf.sv ====
`timescale 1ns/1ps

module fetch_buf
(
    input  logic                i_clk,
    input  logic                i_reset_n,
    input  logic                i_decode_ready,
    fetch_push_if.queue         push_if,
    output logic                o_instr_valid,
    output fetch_pkg::instr_t   o_instr,
    output fetch_pkg::addr_t    o_instr_pc,
    output logic                o_instr_compressed
);

    localparam int HALVES = fetch_pkg::FETCH_BUF_HALVES;

    fetch_pkg::half_t    entries [HALVES];
    fetch_pkg::half_t    entries_next [HALVES];
    fetch_pkg::buf_cnt_t cnt;
    fetch_pkg::buf_cnt_t remain;
    fetch_pkg::buf_cnt_t cnt_next;
    fetch_pkg::buf_cnt_t pop_n;
    fetch_pkg::buf_cnt_t push_n;
    fetch_pkg::half_t    first_half;
    fetch_pkg::addr_t    pc;
    logic                head_comp;
    logic                pop;

    // Low bits 2'b11 mark a 32-bit instruction.
    assign head_comp = (entries[0][1:0] != 2'b11);

    assign o_instr_valid = head_comp ? (cnt != '0) : (cnt > fetch_pkg::buf_cnt_t'(1));

    assign pop    = o_instr_valid && i_decode_ready;
    assign pop_n  = !pop ? '0 :
                    head_comp ? fetch_pkg::buf_cnt_t'(1) : fetch_pkg::buf_cnt_t'(2);
    assign remain = cnt - pop_n;

    assign push_n   = !push_if.push ? '0 :
                      push_if.upper_only ? fetch_pkg::buf_cnt_t'(1) : fetch_pkg::buf_cnt_t'(2);
    assign cnt_next = remain + push_n;

    // Space is judged after the pop, so a full queue draining this cycle
    // can already allow the next request.
    assign push_if.free_dword = (remain <= fetch_pkg::buf_cnt_t'(HALVES - 2));

    assign first_half = push_if.upper_only ? push_if.data[31:16] : push_if.data[15:0];

    always_comb
    begin
        for (int i = 0; i < HALVES; i++)
        begin
            entries_next[i] = entries[i];
            if ((fetch_pkg::buf_cnt_t'(i) < remain) && (i + int'(pop_n) < HALVES))
            begin
                entries_next[i] = entries[i + int'(pop_n)];  // Shift past the popped ones.
            end
            else if (push_if.push && (fetch_pkg::buf_cnt_t'(i) == remain))
            begin
                entries_next[i] = first_half;
            end
            else if (push_if.push && !push_if.upper_only &&
                     (fetch_pkg::buf_cnt_t'(i) == remain + fetch_pkg::buf_cnt_t'(1)))
            begin
                entries_next[i] = push_if.data[31:16];
            end
        end
    end

    always_ff @(posedge i_clk)
    begin
        entries <= entries_next;
    end

    // Flush overrides any pop or push of the same cycle.
    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            cnt <= '0;
            pc  <= fetch_pkg::RESET_PC;
        end
        else if (push_if.flush)
        begin
            cnt <= '0;
            pc  <= push_if.flush_pc;
        end
        else
        begin
            cnt <= cnt_next;
            if (pop)
                pc <= pc + (fetch_pkg::addr_t'(pop_n) << 1);  // 2 or 4 bytes.
        end
    end

    assign o_instr            = head_comp ? {16'h0000, entries[0]} : {entries[1], entries[0]};
    assign o_instr_pc         = pc;
    assign o_instr_compressed = head_comp;

endmodule

// ==== fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit
(
    input  logic                i_clk,
    input  logic                i_reset_n,
    input  logic                i_redirect,
    input  fetch_pkg::addr_t    i_redirect_pc,
    input  logic                i_mem_ack,
    input  fetch_pkg::word_t    i_mem_data,
    input  logic                i_decode_ready,
    output logic                o_mem_req,
    output fetch_pkg::addr_t    o_mem_addr,
    output logic                o_instr_valid,
    output fetch_pkg::instr_t   o_instr,
    output fetch_pkg::addr_t    o_instr_pc,
    output logic                o_instr_compressed
);

    fetch_pkg::addr_t fetch_addr;
    fetch_pkg::addr_t load_pc;
    logic             upper_only;
    logic             load;
    logic             advance;

    fetch_push_if push_bus ();

    fetch_ctrl u_ctrl
    (
        .i_clk          (i_clk),
        .i_reset_n      (i_reset_n),
        .i_redirect     (i_redirect),
        .i_redirect_pc  (i_redirect_pc),
        .i_mem_ack      (i_mem_ack),
        .i_mem_data     (i_mem_data),
        .i_fetch_addr   (fetch_addr),
        .i_upper_only   (upper_only),
        .o_mem_req      (o_mem_req),
        .o_mem_addr     (o_mem_addr),
        .o_load         (load),
        .o_load_pc      (load_pc),
        .o_advance      (advance),
        .push_if        (push_bus.ctrl)
    );

    fetch_addr_gen u_addr_gen
    (
        .i_clk          (i_clk),
        .i_reset_n      (i_reset_n),
        .i_load         (load),
        .i_load_pc      (load_pc),
        .i_advance      (advance),
        .o_fetch_addr   (fetch_addr),
        .o_upper_only   (upper_only)
    );

    fetch_buf u_buf
    (
        .i_clk              (i_clk),
        .i_reset_n          (i_reset_n),
        .i_decode_ready     (i_decode_ready),
        .push_if            (push_bus.queue),
        .o_instr_valid      (o_instr_valid),
        .o_instr            (o_instr),
        .o_instr_pc         (o_instr_pc),
        .o_instr_compressed (o_instr_compressed)
    );

endmodule

// ==== tb_fetch_unit.sv ====
`timescale 1ns/1ps

module tb_fetch_unit;

    localparam int IMG_HALVES = 512;  // 1 KB from RESET_PC, repeating above that.

    logic              clk = 1'b0;
    logic              reset_n;
    logic              redirect;
    fetch_pkg::addr_t  redirect_pc;
    logic              mem_ack = 1'b0;
    fetch_pkg::word_t  mem_data = '0;
    logic              decode_ready;
    logic              mem_req;
    fetch_pkg::addr_t  mem_addr;
    logic              instr_valid;
    fetch_pkg::instr_t instr;
    fetch_pkg::addr_t  instr_pc;
    logic              instr_compressed;

    fetch_pkg::half_t  image [IMG_HALVES];
    fetch_pkg::addr_t  start_pc;
    fetch_pkg::addr_t  exp_pc;
    fetch_pkg::instr_t exp_instr;
    logic              exp_comp;
    int                idx;
    int                n_xfers;
    int                mem_wait;
    string             test_name = "reset";

    fetch_unit UUT
    (
        .i_clk              (clk),
        .i_reset_n          (reset_n),
        .i_redirect         (redirect),
        .i_redirect_pc      (redirect_pc),
        .i_mem_ack          (mem_ack),
        .i_mem_data         (mem_data),
        .i_decode_ready     (decode_ready),
        .o_mem_req          (mem_req),
        .o_mem_addr         (mem_addr),
        .o_instr_valid      (instr_valid),
        .o_instr            (instr),
        .o_instr_pc         (instr_pc),
        .o_instr_compressed (instr_compressed)
    );

    always #50 clk = ~clk;

    function automatic fetch_pkg::half_t image_half(input fetch_pkg::addr_t a);
        fetch_pkg::addr_t off;
        off = (a - fetch_pkg::RESET_PC) >> 1;
        return image[off[8:0]];
    endfunction

    // Walks n instructions from start by the length rule.
    function automatic void ref_walk(input fetch_pkg::addr_t start, input int n,
                                     output fetch_pkg::addr_t pc,
                                     output fetch_pkg::instr_t ins, output logic comp);
        fetch_pkg::half_t h;
        pc = start;
        for (int k = 0; k < n; k++)
        begin
            h = image_half(pc);
            pc = pc + ((h[1:0] != 2'b11) ? 32'd2 : 32'd4);
        end
        h = image_half(pc);
        comp = (h[1:0] != 2'b11);
        ins = comp ? {16'h0000, h} : {image_half(pc + 32'd2), h};
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1, "Simulation stopped.");
    endtask

    task automatic check_addr(input string what, input fetch_pkg::addr_t e,
                              input fetch_pkg::addr_t a);
        if (e !== a)
            report_failure($sformatf("Error: %s %s expected %h actual %h", test_name, what, e, a));
    endtask

    task automatic check_instr(input string what, input fetch_pkg::instr_t e,
                               input fetch_pkg::instr_t a);
        if (e !== a)
            report_failure($sformatf("Error: %s %s expected %h actual %h", test_name, what, e, a));
    endtask

    task automatic check_flag(input string what, input logic e, input logic a);
        if (e !== a)
            report_failure($sformatf("Error: %s %s expected %b actual %b", test_name, what, e, a));
    endtask

    task automatic build_image();
        int               i;
        fetch_pkg::half_t h;
        i = 0;
        while (i < IMG_HALVES)
        begin
            h = fetch_pkg::half_t'($urandom);
            if (($urandom_range(0, 1) == 0) || (i == IMG_HALVES - 1))
            begin
                image[i] = {h[15:2], 2'($urandom_range(0, 2))};  // Compressed.
                i++;
            end
            else
            begin
                image[i] = {h[15:2], 2'b11};
                image[i + 1] = fetch_pkg::half_t'($urandom);
                i += 2;
            end
        end
    endtask

    // Mode 0 stalls decode, 1 keeps it ready, anything else is random.
    task automatic tick(input int mode);
        @(posedge clk);
        if (mode == 0)
            decode_ready <= 1'b0;
        else if (mode == 1)
            decode_ready <= 1'b1;
        else
            decode_ready <= 1'($urandom_range(0, 1));
    endtask

    task automatic run_until(input int target, input int mode);
        int cycles;
        cycles = 0;
        while (n_xfers < target)
        begin
            tick(mode);
            cycles++;
            if (cycles > 20000)
                report_failure($sformatf("Timeout: only %0d of %0d transfers seen.", n_xfers, target));
        end
    endtask

    // Called on a rising edge, so the DUT samples the redirect on the next one.
    task automatic pulse_redirect(input fetch_pkg::addr_t pc);
        redirect    <= 1'b1;
        redirect_pc <= pc;
        @(posedge clk);
        redirect    <= 1'b0;
    endtask

    task automatic wait_open_request();
        int cycles;
        cycles = 0;
        tick(1);
        while (!(mem_req && !mem_ack))
        begin
            cycles++;
            if (cycles > 200)
                report_failure("Timeout: no memory request was raised.");
            tick(1);
        end
    endtask

    always @(posedge clk)
    begin
        if (!reset_n)
            mem_ack <= 1'b0;
        else if (mem_ack)
        begin
            if (!mem_req)
                mem_ack <= 1'b0;  // Fourth phase.
        end
        else if (mem_req)
        begin
            if (mem_addr[1:0] != 2'b00)
                report_failure("Memory request address is not word-aligned.");
            if (mem_wait == 0)
            begin
                mem_ack  <= 1'b1;
                mem_data <= {image_half(mem_addr + 32'd2), image_half(mem_addr)};
            end
            else
                mem_wait <= mem_wait - 1;
        end
        else
            mem_wait <= $urandom_range(0, 5);
    end

    // A transfer on the redirect edge still belongs to the old stream.
    always @(posedge clk)
    begin
        if (!reset_n)
        begin
            start_pc <= fetch_pkg::RESET_PC;
            idx      <= 0;
            n_xfers  <= 0;
        end
        else
        begin
            if (instr_valid && decode_ready)
            begin
                ref_walk(start_pc, idx, exp_pc, exp_instr, exp_comp);
                if (instr_compressed)
                    check_instr("upper bits", '0, instr & 32'hFFFF_0000);
                check_addr("pc", exp_pc, instr_pc);
                check_instr("instruction", exp_instr, instr);
                check_flag("compressed", exp_comp, instr_compressed);
                idx     <= idx + 1;
                n_xfers <= n_xfers + 1;
            end
            if (redirect)
            begin
                start_pc <= redirect_pc;
                idx      <= 0;
            end
        end
    end

    initial
    begin
        reset_n      = 1'b0;
        redirect     = 1'b0;
        redirect_pc  = '0;
        decode_ready = 1'b0;
        void'($urandom(32'h7a7d));
        build_image();
        repeat (4) @(posedge clk);
        reset_n <= 1'b1;

        test_name = "sequential";
        run_until(60, 1);
        test_name = "random ready";
        run_until(140, 2);
        test_name = "long stall";
        for (int c = 0; c < 80; c++)
        begin
            tick(0);
            if (c >= 60)
                check_flag("request while full", 1'b0, mem_req);
        end
        run_until(180, 2);

        test_name = "aligned redirect";
        tick(2);
        pulse_redirect(fetch_pkg::RESET_PC + ($urandom_range(0, 255) << 2));
        run_until(220, 2);
        test_name = "upper half redirect";
        tick(2);
        pulse_redirect(fetch_pkg::RESET_PC + ($urandom_range(0, 255) << 2) + 32'd2);
        run_until(260, 2);

        test_name = "stale response";
        for (int r = 0; r < 4; r++)
        begin
            wait_open_request();
            pulse_redirect(fetch_pkg::RESET_PC + ($urandom_range(0, 511) << 1));
            run_until(280 + 20 * r, 1);
        end
        test_name = "final run";
        run_until(400, 2);

        $display("TESTS PASSED");
        $finish;
    end

endmodule

// ==== sources.f ====
fetch_pkg.sv
fetch_push_if.sv
fetch_ctrl.sv
fetch_addr_gen.sv
fetch_buf.sv
fetch_unit.sv
tb_fetch_unit.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --timescale 1ns/1ps --top-module tb_fetch_unit -f sources.f
./obj_dir/Vtb_fetch_unit | tee sim.log
if grep -q "TESTS PASSED" sim.log; then
    echo "Simulation passed."
else
    echo "Simulation failed."
    exit 1
fi
